/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////
  localparam int dataWidth    = 16;  // Data, instruction and PC word
  localparam int regAddrWidth = 4;   // Register index
  localparam int numRegs      = 16;  // General registers, r0 reads zero
  localparam int memAddrWidth = 8;   // Data memory word address, 256 words
  localparam int pcStep       = 2;   // Byte step between instructions

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////
  localparam int opcodeMsb = 15;  // Opcode in [15:12]
  localparam int rdMsb     = 11;  // Destination in [11:8]
  localparam int rsMsb     = 7;   // First source in [7:4], also top of imm8
  localparam int rtMsb     = 3;   // Second source or signed offset in [3:0]

  // Opcodes of the kept ISA
  // Unlisted codes behave as no-ops
  typedef enum logic [3:0] {
    opAdd = 4'd0,
    opSub = 4'd1,
    opXor = 4'd2,
    opLw  = 4'd8,
    opSw  = 4'd9,
    opLlb = 4'd10,
    opLhb = 4'd11,
    opHlt = 4'd15
  } opcodeT;

  // ALU functions used by execute
  typedef enum logic [2:0] {
    aluAdd,       // Also LW/SW address
    aluSub,
    aluXor,
    aluLowByte,   // LLB, replace low byte of A
    aluHighByte   // LHB, replace high byte of A
  } aluOpT;

  // Opcode 7 with zero fields, decodes as a no-op
  localparam logic [dataWidth-1:0] nopInstr = 16'h7000;

endpackage

`default_nettype wire

/* hw/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          hold,       // Load-use stall or halt from decode
  input  logic [cpuPkg::dataWidth-1:0]  instData,   // Word at pc, same cycle
  output logic [cpuPkg::dataWidth-1:0]  pc,
  output logic [cpuPkg::dataWidth-1:0]  ifIdInstr
);

  logic [cpuPkg::dataWidth-1:0] pcNext;  // Sequential next PC

  // No branches, so the PC only ever steps forward
  assign pcNext = pc + cpuPkg::dataWidth'(cpuPkg::pcStep);

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;              // Start of program
    end else if (!hold) begin
      pc <= pcNext;
    end
    // Under hold the PC keeps pointing at the word already in flight
  end

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////
  // Reset fills the slot with a no-op so decode sees a bubble first
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ifIdInstr <= cpuPkg::nopInstr;
    end else if (!hold) begin
      ifIdInstr <= instData;  // Capture fetched word
    end
  end

  // Hold freezes both registers together, so the held
  // instruction is re-decoded the next cycle and the word
  // on instData is simply fetched again

endmodule

`default_nettype wire

/* hw/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [cpuPkg::regAddrWidth-1:0]  rdAddrA,
  input  logic [cpuPkg::regAddrWidth-1:0]  rdAddrB,
  output logic [cpuPkg::dataWidth-1:0]     rdDataA,
  output logic [cpuPkg::dataWidth-1:0]     rdDataB,
  input  logic                             wrEn,
  input  logic [cpuPkg::regAddrWidth-1:0]  wrAddr,
  input  logic [cpuPkg::dataWidth-1:0]     wrData
);

  logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::numRegs];

  // One read port: r0 is zero, a same-cycle write passes straight through
  function automatic logic [cpuPkg::dataWidth-1:0] readPort(
    input logic [cpuPkg::regAddrWidth-1:0] addr
  );
    if (addr == '0)                     return '0;
    else if (wrEn && (wrAddr == addr))  return wrData;   // Write-through
    else                                return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < cpuPkg::numRegs; i++) regs[i] <= '0;
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;  // r0 never written
    end
  end

  assign rdDataA = readPort(rdAddrA);
  assign rdDataB = readPort(rdAddrB);

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [cpuPkg::dataWidth-1:0]     ifIdInstr,
  input  logic                             wbEn,
  input  logic [cpuPkg::regAddrWidth-1:0]  wbAddr,
  input  logic [cpuPkg::dataWidth-1:0]     wbData,
  output logic                             hold,
  output logic [cpuPkg::regAddrWidth-1:0]  idExSrcA,
  output logic [cpuPkg::regAddrWidth-1:0]  idExSrcB,
  output logic [cpuPkg::dataWidth-1:0]     idExValA,
  output logic [cpuPkg::dataWidth-1:0]     idExValB,
  output logic [cpuPkg::dataWidth-1:0]     idExImm,
  output cpuPkg::aluOpT                    idExAluOp,
  output logic                             idExUseImm,
  output logic [cpuPkg::regAddrWidth-1:0]  idExRd,
  output logic                             idExRegWrite,
  output logic                             idExMemRead,
  output logic                             idExMemWrite,
  output logic                             idExHalt
);

  cpuPkg::opcodeT                  opcode;
  logic [cpuPkg::regAddrWidth-1:0] rd, rs, rt;
  logic [cpuPkg::regAddrWidth-1:0] srcA, srcB;   // Register file read addresses
  logic [cpuPkg::dataWidth-1:0]    valA, valB;
  logic [cpuPkg::dataWidth-1:0]    imm;
  cpuPkg::aluOpT                   aluOp;
  logic useImm, regWrite, memRead, memWrite, isHalt;
  logic useA, useB;      // Which sources the instruction really reads
  logic loadUse;         // Load in ID/EX feeds this instruction
  logic haltFlag;        // Sticky, HLT already passed into ID/EX

  assign opcode = cpuPkg::opcodeT'(ifIdInstr[cpuPkg::opcodeMsb -: 4]);
  assign rd     = ifIdInstr[cpuPkg::rdMsb -: cpuPkg::regAddrWidth];
  assign rs     = ifIdInstr[cpuPkg::rsMsb -: cpuPkg::regAddrWidth];
  assign rt     = ifIdInstr[cpuPkg::rtMsb -: cpuPkg::regAddrWidth];

  ////////////////////////////////////////
  // Instruction decode
  ////////////////////////////////////////
  always_comb begin
    aluOp    = cpuPkg::aluAdd;
    useImm   = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    isHalt   = 1'b0;
    useA     = 1'b0;
    useB     = 1'b0;
    srcA     = rs;
    srcB     = rt;
    // Signed word offset by default
    imm = {{(cpuPkg::dataWidth - cpuPkg::regAddrWidth){rt[cpuPkg::regAddrWidth-1]}}, rt};
    case (opcode)
      cpuPkg::opAdd: begin regWrite = 1'b1; useA = 1'b1; useB = 1'b1; end
      cpuPkg::opSub: begin
        aluOp = cpuPkg::aluSub; regWrite = 1'b1; useA = 1'b1; useB = 1'b1;
      end
      cpuPkg::opXor: begin
        aluOp = cpuPkg::aluXor; regWrite = 1'b1; useA = 1'b1; useB = 1'b1;
      end
      cpuPkg::opLw: begin useImm = 1'b1; regWrite = 1'b1; memRead = 1'b1; useA = 1'b1; end
      cpuPkg::opSw: begin
        useImm = 1'b1; memWrite = 1'b1; useA = 1'b1; useB = 1'b1;
        srcB   = rd;                    // Store data comes from rd
      end
      cpuPkg::opLlb, cpuPkg::opLhb: begin
        aluOp  = (opcode == cpuPkg::opLlb) ? cpuPkg::aluLowByte : cpuPkg::aluHighByte;
        useImm = 1'b1; regWrite = 1'b1; useA = 1'b1;
        srcA   = rd;                    // Keeps the other byte of rd
        imm    = {8'h00, ifIdInstr[cpuPkg::rsMsb:0]};  // imm8
      end
      cpuPkg::opHlt: isHalt = 1'b1;
      default: ;                        // No-op
    endcase
    if (rd == '0) regWrite = 1'b0;      // r0 stays zero
  end

  registerFile uRegFile (
    .clk(clk), .rstN(rstN),
    .rdAddrA(srcA), .rdAddrB(srcB),
    .rdDataA(valA), .rdDataB(valB),
    .wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData)
  );

  // One bubble when the load in EX produces a register read here
  assign loadUse = idExMemRead && idExRegWrite &&
                   ((useA && (idExRd == srcA)) || (useB && (idExRd == srcB)));
  assign hold    = loadUse || haltFlag;

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idExSrcA <= '0; idExSrcB <= '0;
      idExValA <= '0; idExValB <= '0; idExImm <= '0;
      idExAluOp <= cpuPkg::aluAdd; idExUseImm <= 1'b0; idExRd <= '0;
      idExRegWrite <= 1'b0; idExMemRead <= 1'b0; idExMemWrite <= 1'b0;
      idExHalt <= 1'b0;
      haltFlag <= 1'b0;
    end else begin
      idExSrcA   <= srcA;
      idExSrcB   <= srcB;
      idExValA   <= valA;
      idExValB   <= valB;
      idExImm    <= imm;
      idExAluOp  <= aluOp;
      idExUseImm <= useImm;
      idExRd     <= rd;
      // Bubble: every enable low under hold
      idExRegWrite <= regWrite && !hold;
      idExMemRead  <= memRead && !hold;
      idExMemWrite <= memWrite && !hold;
      idExHalt     <= isHalt && !hold;
      haltFlag     <= haltFlag || (isHalt && !hold);  // Stays set until reset
    end
  end

endmodule

`default_nettype wire

/* hw/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [cpuPkg::regAddrWidth-1:0]  idExSrcA,
  input  logic [cpuPkg::regAddrWidth-1:0]  idExSrcB,
  input  logic [cpuPkg::dataWidth-1:0]     idExValA,
  input  logic [cpuPkg::dataWidth-1:0]     idExValB,
  input  logic [cpuPkg::dataWidth-1:0]     idExImm,
  input  cpuPkg::aluOpT                    idExAluOp,
  input  logic                             idExUseImm,
  input  logic [cpuPkg::regAddrWidth-1:0]  idExRd,
  input  logic                             idExRegWrite,
  input  logic                             idExMemRead,
  input  logic                             idExMemWrite,
  input  logic                             idExHalt,
  input  logic                             wbEn,
  input  logic [cpuPkg::regAddrWidth-1:0]  wbAddr,
  input  logic [cpuPkg::dataWidth-1:0]     wbData,
  output logic [cpuPkg::dataWidth-1:0]     exMemAlu,
  output logic [cpuPkg::dataWidth-1:0]     exMemStoreData,
  output logic [cpuPkg::regAddrWidth-1:0]  exMemRd,
  output logic                             exMemRegWrite,
  output logic                             exMemMemRead,
  output logic                             exMemMemWrite,
  output logic                             exMemHalt
);

  logic [cpuPkg::dataWidth-1:0] opA, opB;    // Forwarded operands
  logic [cpuPkg::dataWidth-1:0] aluB;        // opB or immediate
  logic [cpuPkg::dataWidth-1:0] aluOut;

  // Newest producer wins: EX/MEM, then MEM/WB, then the register file value
  function automatic logic [cpuPkg::dataWidth-1:0] forwardOperand(
    input logic [cpuPkg::regAddrWidth-1:0] src,
    input logic [cpuPkg::dataWidth-1:0]    regVal
  );
    if (exMemRegWrite && (exMemRd == src)) return exMemAlu;  // Never a load here
    else if (wbEn && (wbAddr == src))      return wbData;
    else                                   return regVal;
  endfunction

  ////////////////////////////////////////
  // Forwarding and ALU
  ////////////////////////////////////////
  assign opA  = forwardOperand(idExSrcA, idExValA);
  assign opB  = forwardOperand(idExSrcB, idExValB);   // Also SW store data
  assign aluB = idExUseImm ? idExImm : opB;

  always_comb begin
    case (idExAluOp)
      cpuPkg::aluSub:      aluOut = opA - aluB;
      cpuPkg::aluXor:      aluOut = opA ^ aluB;
      cpuPkg::aluLowByte:  aluOut = {opA[15:8], aluB[7:0]};   // LLB
      cpuPkg::aluHighByte: aluOut = {aluB[7:0], opA[7:0]};    // LHB
      default:             aluOut = opA + aluB;   // ADD, LW/SW address
    endcase
  end

  ////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMemAlu       <= '0;
      exMemStoreData <= '0;
      exMemRd        <= '0;
      exMemRegWrite  <= 1'b0;
      exMemMemRead   <= 1'b0;
      exMemMemWrite  <= 1'b0;
      exMemHalt      <= 1'b0;
    end else begin
      exMemAlu       <= aluOut;
      exMemStoreData <= opB;
      exMemRd        <= idExRd;
      exMemRegWrite  <= idExRegWrite;
      exMemMemRead   <= idExMemRead;
      exMemMemWrite  <= idExMemWrite;
      exMemHalt      <= idExHalt;
    end
  end

endmodule

`default_nettype wire

/* hw/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [cpuPkg::dataWidth-1:0]     exMemAlu,
  input  logic [cpuPkg::dataWidth-1:0]     exMemStoreData,
  input  logic [cpuPkg::regAddrWidth-1:0]  exMemRd,
  input  logic                             exMemRegWrite,
  input  logic                             exMemMemRead,
  input  logic                             exMemMemWrite,
  input  logic                             exMemHalt,
  output logic                             wbEn,
  output logic [cpuPkg::regAddrWidth-1:0]  wbAddr,
  output logic [cpuPkg::dataWidth-1:0]     wbData,
  output logic                             halted
);

  localparam int memDepth = 2 ** cpuPkg::memAddrWidth;

  logic [cpuPkg::dataWidth-1:0]    dataMem [memDepth];
  logic [cpuPkg::memAddrWidth-1:0] memAddr;     // Address wraps to 8 bits
  logic [cpuPkg::dataWidth-1:0]    readData;
  logic [cpuPkg::dataWidth-1:0]    memWbLoad, memWbAlu;
  logic                            memWbMemRead, memWbHalt;
  logic                            haltSeen;

  assign memAddr  = exMemAlu[cpuPkg::memAddrWidth-1:0];
  assign readData = dataMem[memAddr];  // Combinational read

  ////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < memDepth; i++) dataMem[i] <= '0;
    end else if (exMemMemWrite) begin
      dataMem[memAddr] <= exMemStoreData;
    end
  end

  ////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWbLoad <= '0; memWbAlu <= '0; memWbMemRead <= 1'b0;
      wbAddr <= '0; wbEn <= 1'b0; memWbHalt <= 1'b0; haltSeen <= 1'b0;
    end else begin
      memWbLoad    <= readData;
      memWbAlu     <= exMemAlu;
      memWbMemRead <= exMemMemRead;
      wbAddr       <= exMemRd;
      wbEn         <= exMemRegWrite;
      memWbHalt    <= exMemHalt;
      haltSeen     <= haltSeen || memWbHalt;   // Keep halt after HLT leaves WB
    end
  end

  assign wbData = memWbMemRead ? memWbLoad : memWbAlu;  // Writeback select
  assign halted = memWbHalt || haltSeen;

endmodule

`default_nettype wire

/* hw/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [cpuPkg::dataWidth-1:0]     instData,  // From external instruction memory
  output logic [cpuPkg::dataWidth-1:0]     pc,
  output logic                             hlt,
  output logic                             wbEn,
  output logic [cpuPkg::regAddrWidth-1:0]  wbAddr,
  output logic [cpuPkg::dataWidth-1:0]     wbData
);

  ////////////////////////////////////////
  // Stage-to-stage nets
  ////////////////////////////////////////
  logic                            hold;        // Decode freezes fetch
  logic [cpuPkg::dataWidth-1:0]    ifIdInstr;

  logic [cpuPkg::regAddrWidth-1:0] idExSrcA, idExSrcB, idExRd;
  logic [cpuPkg::dataWidth-1:0]    idExValA, idExValB, idExImm;
  cpuPkg::aluOpT                   idExAluOp;
  logic idExUseImm, idExRegWrite, idExMemRead, idExMemWrite, idExHalt;

  logic [cpuPkg::dataWidth-1:0]    exMemAlu, exMemStoreData;
  logic [cpuPkg::regAddrWidth-1:0] exMemRd;
  logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemHalt;

  fetchStage uFetch (
    .clk(clk), .rstN(rstN), .hold(hold),
    .instData(instData), .pc(pc), .ifIdInstr(ifIdInstr)
  );

  // Writeback feeds the register file here
  decodeStage uDecode (
    .clk(clk), .rstN(rstN), .ifIdInstr(ifIdInstr),
    .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .hold(hold),
    .idExSrcA(idExSrcA), .idExSrcB(idExSrcB),
    .idExValA(idExValA), .idExValB(idExValB), .idExImm(idExImm),
    .idExAluOp(idExAluOp), .idExUseImm(idExUseImm), .idExRd(idExRd),
    .idExRegWrite(idExRegWrite), .idExMemRead(idExMemRead),
    .idExMemWrite(idExMemWrite), .idExHalt(idExHalt)
  );

  // and the second forwarding path here
  executeStage uExecute (
    .clk(clk), .rstN(rstN),
    .idExSrcA(idExSrcA), .idExSrcB(idExSrcB),
    .idExValA(idExValA), .idExValB(idExValB), .idExImm(idExImm),
    .idExAluOp(idExAluOp), .idExUseImm(idExUseImm), .idExRd(idExRd),
    .idExRegWrite(idExRegWrite), .idExMemRead(idExMemRead),
    .idExMemWrite(idExMemWrite), .idExHalt(idExHalt),
    .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
    .exMemAlu(exMemAlu), .exMemStoreData(exMemStoreData), .exMemRd(exMemRd),
    .exMemRegWrite(exMemRegWrite), .exMemMemRead(exMemMemRead),
    .exMemMemWrite(exMemMemWrite), .exMemHalt(exMemHalt)
  );

  memoryStage uMemory (
    .clk(clk), .rstN(rstN),
    .exMemAlu(exMemAlu), .exMemStoreData(exMemStoreData), .exMemRd(exMemRd),
    .exMemRegWrite(exMemRegWrite), .exMemMemRead(exMemMemRead),
    .exMemMemWrite(exMemMemWrite), .exMemHalt(exMemHalt),
    .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
    .halted(hlt)                       // High from HLT in WB until reset
  );

endmodule

`default_nettype wire

/* bench/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

  localparam int resetCycles   = 8;
  localparam int haltWatch     = 6;    // Cycles watched after hlt rises
  localparam int randomLen     = 40;
  localparam int maxProgWords  = randomLen + 1;
  localparam int numTests      = 6;    // Three directed and three random
  localparam int imemAddrBits  = 6;
  localparam int imemWords     = 2 ** imemAddrBits;
  // Twice the instruction count plus 40 per test plus the reset and halt windows
  localparam int budgetCycles  =
    numTests * (2 * maxProgWords + 40 + resetCycles + haltWatch + 2);

  logic                            clk;
  logic                            rstN;
  logic [cpuPkg::dataWidth-1:0]    instData;
  logic [cpuPkg::dataWidth-1:0]    pc;
  logic                            hlt;
  logic                            wbEn;
  logic [cpuPkg::regAddrWidth-1:0] wbAddr;
  logic [cpuPkg::dataWidth-1:0]    wbData;

  logic [cpuPkg::dataWidth-1:0] imem [imemWords];               // Instruction memory
  logic [cpuPkg::dataWidth-1:0] prog [$];                       // Program being built
  logic [cpuPkg::dataWidth-1:0] modelRegs [cpuPkg::numRegs];
  logic [cpuPkg::dataWidth-1:0] modelMem [2**cpuPkg::memAddrWidth];
  logic [cpuPkg::regAddrWidth-1:0] expAddr [$];                 // Expected writes in order
  logic [cpuPkg::dataWidth-1:0]    expData [$];
  int unsigned lcgState;
  int          valueErrors;
  int          otherErrors;
  string       testName;

  cpu dut (
    .clk(clk), .rstN(rstN), .instData(instData), .pc(pc),
    .hlt(hlt), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
  );

  always #50 clk = ~clk;   // 100 ns period

  assign instData = imem[pc[imemAddrBits:1]];   // Same-cycle fetch by word address

  ////////////////////////////////////////
  // Encoding and random programs
  ////////////////////////////////////////
  function automatic logic [15:0] rInstr(input cpuPkg::opcodeT op, input int rd,
                                         input int rs, input int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};   // rt doubles as signed offset
  endfunction

  function automatic logic [15:0] immInstr(input cpuPkg::opcodeT op, input int rd,
                                           input int imm);
    return {op, 4'(rd), 8'(imm)};
  endfunction

  function automatic int unsigned nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;   // Upper bits have the longer period
  endfunction

  function automatic logic [15:0] randomInstr();
    int unsigned    pick;
    int unsigned    fields;
    cpuPkg::opcodeT op;
    pick   = nextRandom() % 7;
    fields = nextRandom();
    case (pick)
      0: op = cpuPkg::opAdd;
      1: op = cpuPkg::opSub;
      2: op = cpuPkg::opXor;
      3: op = cpuPkg::opLw;
      4: op = cpuPkg::opSw;
      5: op = cpuPkg::opLlb;
      default: op = cpuPkg::opLhb;
    endcase
    // Registers kept to r0..r7 so hazards come up often
    if (op == cpuPkg::opLlb || op == cpuPkg::opLhb)
      return immInstr(op, int'(fields[2:0]), int'(fields[15:8]));
    return rInstr(op, int'(fields[2:0]), int'(fields[5:3]), int'(fields[11:8]));
  endfunction

  ////////////////////////////////////////
  // ISA reference model
  ////////////////////////////////////////
  // Steps one instruction on the model state and returns 1 on a register write
  function automatic logic refStep(input logic [15:0] instr,
                                   output logic [cpuPkg::regAddrWidth-1:0] addr,
                                   output logic [cpuPkg::dataWidth-1:0] data);
    logic [3:0]  op, rd, rs, rt;
    logic [15:0] a, b, offs;
    logic [cpuPkg::memAddrWidth-1:0] memIdx;
    logic writes;
    op     = instr[15:12];
    rd     = instr[11:8];
    rs     = instr[7:4];
    rt     = instr[3:0];
    a      = modelRegs[rs];
    b      = modelRegs[rt];
    offs   = {{12{rt[3]}}, rt};           // Signed word offset
    memIdx = cpuPkg::memAddrWidth'(a + offs);
    addr   = rd;
    data   = '0;
    writes = 1'b0;
    case (op)
      cpuPkg::opAdd: begin
        data   = a + b;
        writes = 1'b1;
      end
      cpuPkg::opSub: begin
        data   = a - b;
        writes = 1'b1;
      end
      cpuPkg::opXor: begin
        data   = a ^ b;
        writes = 1'b1;
      end
      cpuPkg::opLw: begin
        data   = modelMem[memIdx];
        writes = 1'b1;
      end
      cpuPkg::opSw:  modelMem[memIdx] = modelRegs[rd];
      cpuPkg::opLlb: begin
        data   = {modelRegs[rd][15:8], instr[7:0]};
        writes = 1'b1;
      end
      cpuPkg::opLhb: begin
        data   = {instr[7:0], modelRegs[rd][7:0]};
        writes = 1'b1;
      end
      default: ;                           // HLT and no-ops
    endcase
    if (rd == 4'd0) writes = 1'b0;         // r0 stays zero
    if (writes) modelRegs[rd] = data;
    return writes;
  endfunction

  task automatic checkValue(input string what, input logic [15:0] expected,
                            input logic [15:0] actual);
    assert (actual === expected) else begin
      valueErrors++;
      $display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  // Writeback checks at the falling edge where the WB outputs are stable
  always @(negedge clk) begin
    logic [cpuPkg::regAddrWidth-1:0] eAddr;
    logic [cpuPkg::dataWidth-1:0]    eData;
    if (rstN && wbEn) begin
      assert (wbAddr != '0) else begin
        otherErrors++;
        $display("%s: a write to register 0 reached writeback", testName);
      end
      assert (expAddr.size() != 0) else begin
        otherErrors++;
        $display("%s: writeback to r%0d when no write was expected", testName, wbAddr);
      end
      if (expAddr.size() != 0) begin
        eAddr = expAddr.pop_front();
        eData = expData.pop_front();
        checkValue("wbAddr", 16'(eAddr), 16'(wbAddr));
        checkValue("wbData", eData, wbData);
      end
    end
  end

  ////////////////////////////////////////
  // Program runner
  ////////////////////////////////////////
  task automatic runProgram(input string name);
    logic [cpuPkg::regAddrWidth-1:0] wAddr;
    logic [cpuPkg::dataWidth-1:0]    wData;
    logic [cpuPkg::dataWidth-1:0]    haltPc;
    testName = name;
    @(posedge clk);
    rstN <= 1'b0;
    // Words beyond the program hold LLB r1 with their own word address
    for (int i = 0; i < imemWords; i++) imem[i] = {cpuPkg::opLlb, 4'h1, 8'(i)};
    foreach (prog[i]) imem[i] = prog[i];
    for (int i = 0; i < cpuPkg::numRegs; i++) modelRegs[i] = '0;
    for (int i = 0; i < 2**cpuPkg::memAddrWidth; i++) modelMem[i] = '0;
    expAddr.delete();
    expData.delete();
    for (int i = 0; i < prog.size(); i++) begin
      if (prog[i][15:12] == cpuPkg::opHlt) break;   // Nothing past HLT retires
      if (refStep(prog[i], wAddr, wData)) begin
        expAddr.push_back(wAddr);
        expData.push_back(wData);
      end
    end
    repeat (resetCycles) begin
      @(negedge clk);
      checkValue("pc in reset", '0, pc);
      checkValue("hlt in reset", '0, 16'(hlt));
      checkValue("wbEn in reset", '0, 16'(wbEn));
    end
    @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkValue("pc after reset", '0, pc);
    checkValue("hlt after reset", '0, 16'(hlt));
    checkValue("wbEn after reset", '0, 16'(wbEn));
    while (hlt !== 1'b1) @(negedge clk);
    assert (expAddr.size() == 0) else begin
      otherErrors++;
      $display("%s: halted with %0d expected writebacks missing", testName, expAddr.size());
    end
    haltPc = pc;
    repeat (haltWatch) begin
      @(negedge clk);
      checkValue("hlt held", 16'd1, 16'(hlt));
      checkValue("pc frozen", haltPc, pc);
    end
  endtask

  initial begin
    repeat (budgetCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", budgetCycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rstN        = 1'b0;
    lcgState    = 83456;
    valueErrors = 0;
    otherErrors = 0;
    testName    = "init";
    for (int i = 0; i < imemWords; i++) imem[i] = {cpuPkg::opLlb, 4'h1, 8'(i)};

    // Dependent ALU chain, byte loads and r0 writes
    prog.delete();
    prog.push_back(immInstr(cpuPkg::opLlb, 1, 8'h34));
    prog.push_back(immInstr(cpuPkg::opLhb, 1, 8'h12));   // rd source from EX/MEM
    prog.push_back(immInstr(cpuPkg::opLlb, 2, 8'hF0));
    prog.push_back(rInstr(cpuPkg::opAdd, 3, 1, 2));      // Both forwarding paths
    prog.push_back(rInstr(cpuPkg::opSub, 4, 3, 1));      // r1 via write-through
    prog.push_back(rInstr(cpuPkg::opXor, 5, 4, 3));
    prog.push_back(rInstr(cpuPkg::opAdd, 6, 5, 4));
    prog.push_back(rInstr(cpuPkg::opAdd, 7, 6, 3));      // r3 from the register file
    prog.push_back(rInstr(cpuPkg::opAdd, 0, 1, 2));      // Dropped write
    prog.push_back(rInstr(cpuPkg::opAdd, 8, 0, 1));
    prog.push_back(rInstr(cpuPkg::opSub, 9, 0, 1));
    prog.push_back(rInstr(cpuPkg::opXor, 10, 9, 0));
    prog.push_back(rInstr(cpuPkg::opHlt, 0, 0, 0));
    runProgram("alu_forward");

    // Store then load, load-use on rs, store data and byte-load source
    prog.delete();
    prog.push_back(immInstr(cpuPkg::opLlb, 1, 8'h10));
    prog.push_back(immInstr(cpuPkg::opLlb, 2, 8'h5A));
    prog.push_back(immInstr(cpuPkg::opLhb, 2, 8'hA5));
    prog.push_back(rInstr(cpuPkg::opSw, 2, 1, 3));       // Store data forwarded
    prog.push_back(rInstr(cpuPkg::opLw, 3, 1, 3));
    prog.push_back(rInstr(cpuPkg::opAdd, 4, 3, 3));      // Load-use stall
    prog.push_back(rInstr(cpuPkg::opSw, 4, 1, -2));
    prog.push_back(rInstr(cpuPkg::opLw, 5, 1, -2));
    prog.push_back(rInstr(cpuPkg::opSw, 5, 1, 0));       // Stall on store data
    prog.push_back(rInstr(cpuPkg::opLw, 6, 1, 0));
    prog.push_back(immInstr(cpuPkg::opLlb, 6, 8'h77));   // Stall on LLB source
    prog.push_back(rInstr(cpuPkg::opLw, 7, 0, 5));
    prog.push_back(rInstr(cpuPkg::opXor, 8, 7, 6));
    prog.push_back(rInstr(cpuPkg::opHlt, 0, 0, 0));
    runProgram("load_store");

    // Writes after HLT must never retire
    prog.delete();
    prog.push_back(immInstr(cpuPkg::opLlb, 1, 8'h11));
    prog.push_back(rInstr(cpuPkg::opAdd, 2, 1, 1));
    prog.push_back(rInstr(cpuPkg::opHlt, 0, 0, 0));
    prog.push_back(immInstr(cpuPkg::opLlb, 3, 8'h33));
    prog.push_back(rInstr(cpuPkg::opAdd, 4, 1, 1));
    prog.push_back(rInstr(cpuPkg::opHlt, 0, 0, 0));
    runProgram("early_halt");

    for (int t = 0; t < 3; t++) begin
      prog.delete();
      repeat (randomLen) prog.push_back(randomInstr());
      prog.push_back(rInstr(cpuPkg::opHlt, 0, 0, 0));
      runProgram($sformatf("random_%0d", t));
    end

    $display("Errors: %0d total (%0d value mismatches, %0d other failures)",
             valueErrors + otherErrors, valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hw/cpuPkg.sv
hw/fetchStage.sv
hw/registerFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/cpu.sv
bench/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= cpuTb
FILELIST  ?= sources.f

BUILD_DIR := obj_dir
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
